// ==== alu.sv ====
module alu import rvPkg::*;
(
	input aluOpT aluOp,
	input dataT x,
	input dataT y,
	output dataT out
);

	logic [4:0] shamt;
	logic lessSigned;
	logic lessUnsigned;

	assign shamt = y[4:0]; // only low 5 bits shift
	assign lessSigned = $signed(x) < $signed(y);
	assign lessUnsigned = x < y;

	always_comb
	begin
		out = '0;
		case (aluOp)
			ADD: out = x + y;
			SUB: out = x - y;
			SLL: out = x << shamt;
			SRL: out = x >> shamt;
			SRA: out = dataT'($signed(x) >>> shamt);
			SLT: out = {31'd0, lessSigned};
			SLTU: out = {31'd0, lessUnsigned};
			XOR: out = x ^ y;
			OR: out = x | y;
			AND: out = x & y;
			EQ: out = {31'd0, x == y};
			NE: out = {31'd0, x != y};
			GE: out = {31'd0, ~lessSigned};
			GEU: out = {31'd0, ~lessUnsigned};
			default: out = '0;
		endcase
	end

endmodule

// ==== exBus.sv ====
interface exBus import rvPkg::*; ();

	wbKindT kind; // IDLE means empty slot
	dataT result; // alu output, imm for lui
	addrT target; // jump or branch destination
	dataT link; // pc + 4

	// producer side
	modport source
	(
		output kind,
		output result,
		output target,
		output link
	);

	// consumer side
	modport sink
	(
		input kind,
		input result,
		input target,
		input link
	);

endinterface

// ==== exStageReg.sv ====
module exStageReg import rvPkg::*;
(
	input logic clk,
	input logic reset,
	exBus.sink exIn,
	exBus.source exOut
);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			exOut.kind <= IDLE; // empty slot after reset
			exOut.result <= '0;
			exOut.target <= '0;
			exOut.link <= '0;
		end
		else
		begin
			exOut.kind <= exIn.kind;
			exOut.result <= exIn.result;
			exOut.target <= exIn.target;
			exOut.link <= exIn.link;
		end
	end

endmodule

// ==== executeUnit.sv ====
module executeUnit import rvPkg::*;
(
	input logic clk,
	input logic reset,
	input opcodeT opcode,
	input func3T func3,
	input func7T func7,
	input dataT regReadData0,
	input dataT regReadData1,
	input dataT imm,
	input addrT pcReadData,
	output logic regWriteEnable,
	output dataT regWriteData,
	output logic pcWriteEnable,
	output addrT pcWriteData
);

	exBus decBus(); // decoder to stage register
	exBus regBus(); // stage register to controller

	opDecoder opDecoder_inst
	(
		.opcode(opcode),
		.func3(func3),
		.func7(func7),
		.regReadData0(regReadData0),
		.regReadData1(regReadData1),
		.imm(imm),
		.pcReadData(pcReadData),
		.pcWriteEnable(pcWriteEnable), // branch shadow feedback
		.exOut(decBus.source)
	);

	exStageReg exStageReg_inst
	(
		.clk(clk),
		.reset(reset),
		.exIn(decBus.sink),
		.exOut(regBus.source)
	);

	wbController wbController_inst
	(
		.clk(clk),
		.reset(reset),
		.exIn(regBus.sink),
		.regWriteEnable(regWriteEnable),
		.regWriteData(regWriteData),
		.pcWriteEnable(pcWriteEnable),
		.pcWriteData(pcWriteData)
	);

endmodule

// ==== opDecoder.sv ====
module opDecoder import rvPkg::*;
(
	input opcodeT opcode,
	input func3T func3,
	input func7T func7,
	input dataT regReadData0,
	input dataT regReadData1,
	input dataT imm,
	input addrT pcReadData,
	input logic pcWriteEnable,
	exBus.source exOut
);

	aluOpT aluOp;
	dataT aluX;
	dataT aluY;
	dataT aluOut;
	addrT pcRelTarget;
	addrT jalrSum;
	dataT linkAddr;
	logic useImm; // lui bypasses the alu

	assign pcRelTarget = pcReadData + imm; // jal and branch destination
	assign jalrSum = regReadData0 + imm; // rs1 + imm for jalr
	assign linkAddr = pcReadData + 32'd4;

	always_comb
	begin
		aluOp = ADD;
		aluX = regReadData0;
		aluY = regReadData1;
		useImm = 1'b0;
		exOut.kind = IDLE;
		exOut.target = pcRelTarget;

		// shadow of a taken branch or jump, drop this slot
		if (!pcWriteEnable)
		begin
			case (opcode)
				OP_R:
				begin
					case (func3)
						3'd0: aluOp = func7[5] ? SUB : ADD;
						3'd1: aluOp = SLL;
						3'd2: aluOp = SLT;
						3'd3: aluOp = SLTU;
						3'd4: aluOp = XOR;
						3'd5: aluOp = func7[5] ? SRA : SRL;
						3'd6: aluOp = OR;
						default: aluOp = AND;
					endcase
					exOut.kind = REGWRITE;
				end
				OP_IMM:
				begin
					case (func3)
						3'd0: aluOp = ADD;
						3'd1: aluOp = SLL;
						3'd2: aluOp = SLT;
						3'd3: aluOp = SLTU;
						3'd4: aluOp = XOR;
						3'd5: aluOp = imm[10] ? SRA : SRL; // srai sits in imm[10]
						3'd6: aluOp = OR;
						default: aluOp = AND;
					endcase
					aluY = imm;
					exOut.kind = REGWRITE;
				end
				OP_LUI:
				begin
					useImm = 1'b1;
					exOut.kind = REGWRITE;
				end
				OP_AUIPC:
				begin
					aluX = pcReadData;
					aluY = imm;
					exOut.kind = REGWRITE;
				end
				OP_BRANCH:
				begin
					exOut.kind = BRANCH;
					case (func3)
						F3_BEQ: aluOp = EQ;
						F3_BNE: aluOp = NE;
						F3_BLT: aluOp = SLT;
						F3_BGE: aluOp = GE;
						F3_BLTU: aluOp = SLTU;
						F3_BGEU: aluOp = GEU;
						default: exOut.kind = IDLE; // reserved encodings
					endcase
				end
				OP_JAL:
				begin
					aluX = pcReadData;
					aluY = imm;
					exOut.kind = JUMP;
				end
				OP_JALR:
				begin
					aluY = imm;
					exOut.target = {jalrSum[31:1], 1'b0}; // lsb cleared
					exOut.kind = JUMP;
				end
				default: exOut.kind = IDLE; // loads, stores, unknown
			endcase
		end
	end

	assign exOut.result = useImm ? imm : aluOut;
	assign exOut.link = linkAddr;

	alu alu_inst
	(
		.aluOp(aluOp),
		.x(aluX),
		.y(aluY),
		.out(aluOut)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
verilator --binary --top-module tbExecute -f src.f -o simExecute \
	&& ./obj_dir/simExecute > sim.log 2>&1 \
	|| { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0

// ==== rvPkg.sv ====
package rvPkg;

	// widths fixed by the RV32I ISA
	typedef logic [31:0] dataT; // operand or result word
	typedef logic [31:0] addrT; // program counter
	typedef logic [6:0] opcodeT; // major opcode
	typedef logic [2:0] func3T; // minor opcode
	typedef logic [6:0] func7T; // function field

	// operations the execute ALU can perform
	typedef enum logic [4:0]
	{
		ADD = 5'd0,
		SUB = 5'd1,
		SLL = 5'd2,
		SRL = 5'd3,
		SRA = 5'd4,
		SLT = 5'd5, // signed less than
		SLTU = 5'd6, // unsigned less than
		XOR = 5'd7,
		OR = 5'd8,
		AND = 5'd9,
		EQ = 5'd10, // branch compares
		NE = 5'd11,
		GE = 5'd12,
		GEU = 5'd13
	} aluOpT;

	// what the write-back step does with a result
	typedef enum logic [2:0]
	{
		IDLE = 3'd0, // nothing to do
		REGWRITE = 3'd1, // result to rd
		BRANCH = 3'd2, // conditional pc write
		JUMP = 3'd3 // link to rd, target to pc
	} wbKindT;

	// major opcodes handled by the slice
	localparam opcodeT OP_R = 7'b0110011;
	localparam opcodeT OP_IMM = 7'b0010011;
	localparam opcodeT OP_LUI = 7'b0110111;
	localparam opcodeT OP_AUIPC = 7'b0010111;
	localparam opcodeT OP_BRANCH = 7'b1100011;
	localparam opcodeT OP_JAL = 7'b1101111;
	localparam opcodeT OP_JALR = 7'b1100111;

	// branch func3 codes, 2 and 3 are reserved
	localparam func3T F3_BEQ = 3'd0;
	localparam func3T F3_BNE = 3'd1;
	localparam func3T F3_BLT = 3'd4;
	localparam func3T F3_BGE = 3'd5;
	localparam func3T F3_BLTU = 3'd6;
	localparam func3T F3_BGEU = 3'd7;

endpackage

// ==== src.f ====
rvPkg.sv
exBus.sv
alu.sv
opDecoder.sv
exStageReg.sv
wbController.sv
executeUnit.sv
tbExecute.sv

// ==== tbExecute.sv ====
module tbExecute import rvPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// write-back expected from one issued slot
	typedef struct packed
	{
		logic regWe;
		dataT regWd;
		logic pcWe;
		addrT pcWd;
	} expT;

	logic clk = 1'b0;
	logic reset = 1'b1;
	opcodeT opcode = '0;
	func3T func3 = '0;
	func7T func7 = '0;
	dataT regReadData0 = '0;
	dataT regReadData1 = '0;
	dataT imm = '0;
	addrT pcReadData = '0;
	logic regWriteEnable;
	dataT regWriteData;
	logic pcWriteEnable;
	addrT pcWriteData;
	expT older = '0; // issued two slots back
	expT newer = '0; // issued one slot back
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int failedTests = 0;

	always #5 clk = ~clk;

	executeUnit executeUnit_inst (.*);

	// RV32I integer op semantics, alt selects sub or sra
	function automatic dataT arithRef(func3T f3, logic alt, dataT a, dataT b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? dataT'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchRef(func3T f3, dataT a, dataT b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0; // reserved encodings
		endcase
	endfunction

	// nothing is written for a slot sampled while the pc is being written
	function automatic expT modelRef(opcodeT op, func3T f3, func7T f7, dataT a, dataT b,
		dataT im, addrT pc, logic shadow);
		expT e;
		e = '0;
		e.pcWd = (op == OP_JALR) ? ((a + im) & ~32'd1) : pc + im;
		if (!shadow)
		begin
			case (op)
				OP_R: e.regWd = arithRef(f3, f7[5], a, b);
				OP_IMM: e.regWd = arithRef(f3, f3 == 3'd5 && im[10], a, im);
				OP_LUI: e.regWd = im;
				OP_AUIPC: e.regWd = pc + im;
				OP_BRANCH: e.pcWe = branchRef(f3, a, b);
				OP_JAL, OP_JALR: e.regWd = pc + 32'd4;
				default: e.regWd = '0;
			endcase
			e.regWe = op == OP_R || op == OP_IMM || op == OP_LUI || op == OP_AUIPC
				|| op == OP_JAL || op == OP_JALR;
			if (op == OP_JAL || op == OP_JALR)
				e.pcWe = 1'b1;
		end
		return e;
	endfunction

	task automatic checkValue(string name, dataT got, dataT want);
		if (got !== want)
		begin
			$display("FAIL %s: got %h, expected %h", name, got, want);
			errorCount++;
		end
	endtask

	// drive one slot, then check the slot issued two edges earlier
	task automatic step(opcodeT op, func3T f3, func7T f7, dataT a, dataT b, dataT im,
		addrT pc);
		expT e;
		e = modelRef(op, f3, f7, a, b, im, pc, older.pcWe);
		@(posedge clk);
		opcode <= op;
		func3 <= f3;
		func7 <= f7;
		regReadData0 <= a;
		regReadData1 <= b;
		imm <= im;
		pcReadData <= pc;
		@(negedge clk);
		checkCount++;
		checkValue("regWriteEnable", {31'd0, regWriteEnable}, {31'd0, older.regWe});
		checkValue("pcWriteEnable", {31'd0, pcWriteEnable}, {31'd0, older.pcWe});
		if (older.regWe)
			checkValue("regWriteData", regWriteData, older.regWd);
		if (older.pcWe)
			checkValue("pcWriteData", pcWriteData, older.pcWd);
		older = newer;
		newer = e;
	endtask

	task automatic flush();
		step(7'd0, 3'd0, 7'd0, '0, '0, '0, '0);
		step(7'd0, 3'd0, 7'd0, '0, '0, '0, '0);
	endtask

	task automatic waitPcWrite();
		int n;
		for (n = 0; n < 20 && pcWriteEnable !== 1'b1; n++)
			step(7'd0, 3'd0, 7'd0, '0, '0, '0, '0);
		if (pcWriteEnable !== 1'b1)
		begin
			$display("timeout: pcWriteEnable did not rise within 20 cycles");
			errorCount++;
		end
	endtask

	task automatic reportTest(string name, int startErrors);
		testCount++;
		if (errorCount != startErrors)
			failedTests++;
		$display("test %s: %0d errors", name, errorCount - startErrors);
	endtask

	task automatic rTypeTest();
		int startErrors;
		int i;
		dataT r;
		startErrors = errorCount;
		for (i = 0; i < 50; i++)
		begin
			r = $urandom();
			step(OP_R, r[2:0], {1'b0, r[3], 5'd0}, $urandom(), $urandom(), '0, r);
		end
		flush();
		reportTest("r-type", startErrors);
	endtask

	task automatic iTypeTest();
		int startErrors;
		int i;
		dataT r;
		dataT im;
		startErrors = errorCount;
		for (i = 0; i < 50; i++)
		begin
			r = $urandom();
			im = {{20{r[11]}}, r[11:0]};
			if (r[2:0] == 3'd1 || r[2:0] == 3'd5)
				im = {21'd0, r[10], 5'd0, r[8:4]}; // shamt, bit 10 marks srai
			step(OP_IMM, r[2:0], 7'd0, $urandom(), '0, im, '0);
		end
		flush();
		reportTest("i-type", startErrors);
	endtask

	task automatic upperTest();
		int startErrors;
		int i;
		startErrors = errorCount;
		for (i = 0; i < 8; i++)
			step(i[0] ? OP_AUIPC : OP_LUI, 3'd0, 7'd0, $urandom(), '0,
				$urandom() & 32'hffff_f000, $urandom() & 32'hffff_fffc);
		flush();
		reportTest("lui/auipc", startErrors);
	endtask

	task automatic branchTest();
		int startErrors;
		int i;
		int j;
		dataT r;
		func3T codes [6];
		dataT lhs [3];
		dataT rhs [3];
		startErrors = errorCount;
		codes = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		lhs = '{32'h10, 32'h10, 32'hffff_fff0}; // equal, small vs large, large vs small
		rhs = '{32'h10, 32'hffff_fff0, 32'h10};
		for (i = 0; i < 6; i++)
			for (j = 0; j < 3; j++)
			begin
				r = $urandom();
				step(OP_BRANCH, codes[i], 7'd0, lhs[j], rhs[j], {{19{r[12]}}, r[12:1], 1'b0},
					r & 32'hffff_fffc);
				step(OP_IMM, 3'd0, 7'd0, lhs[j], '0, 32'd1, '0); // ahead of the pc write
				step(OP_IMM, 3'd0, 7'd0, rhs[j], '0, 32'd2, '0); // shadow slot if taken
				flush();
			end
		reportTest("branch", startErrors);
	endtask

	task automatic jumpTest();
		int startErrors;
		int i;
		dataT r;
		addrT pc;
		startErrors = errorCount;
		for (i = 0; i < 4; i++)
		begin
			r = $urandom();
			pc = $urandom() & 32'hffff_fffc;
			step(OP_JAL, 3'd0, 7'd0, '0, '0, {{11{r[20]}}, r[20:1], 1'b0}, pc);
			waitPcWrite();
			// odd rs1 plus even imm leaves bit 0 set before clearing
			step(OP_JALR, 3'd0, 7'd0, $urandom() | 32'd1, '0, {{20{r[11]}}, r[11:1], 1'b0}, pc);
			waitPcWrite();
			flush();
		end
		reportTest("jal/jalr", startErrors);
	endtask

	task automatic unsupportedTest();
		int startErrors;
		startErrors = errorCount;
		step(7'b0000011, 3'd2, 7'd0, $urandom(), '0, $urandom(), '0); // lw
		step(7'b0100011, 3'd2, 7'd0, $urandom(), $urandom(), $urandom(), '0); // sw
		step(7'b0001111, 3'd0, 7'd0, '0, '0, '0, '0); // fence
		step(7'b1111111, 3'd7, 7'h7f, $urandom(), $urandom(), $urandom(), '0);
		step(OP_BRANCH, 3'd2, 7'd0, 32'd1, 32'd1, 32'd8, '0); // reserved func3
		step(OP_BRANCH, 3'd3, 7'd0, 32'd1, 32'd2, 32'd8, '0);
		flush();
		reportTest("unsupported", startErrors);
	endtask

	task automatic resetTest();
		int startErrors;
		int i;
		startErrors = errorCount;
		step(OP_IMM, 3'd0, 7'd0, 32'd5, '0, 32'd7, '0); // in flight when reset hits
		@(posedge clk);
		reset <= 1'b1;
		opcode <= '0;
		for (i = 0; i < 3; i++)
		begin
			@(posedge clk);
			@(negedge clk);
			checkCount++;
			checkValue("regWriteEnable", {31'd0, regWriteEnable}, 32'd0);
			checkValue("pcWriteEnable", {31'd0, pcWriteEnable}, 32'd0);
		end
		@(posedge clk);
		reset <= 1'b0;
		older = '0;
		newer = '0;
		flush();
		reportTest("reset", startErrors);
	endtask

	initial
	begin
		void'($urandom(32'hc94e4bf0));
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		rTypeTest();
		iTypeTest();
		upperTest();
		branchTest();
		jumpTest();
		unsupportedTest();
		resetTest();
		$display("tests %0d, failed %0d, checks %0d, errors %0d", testCount, failedTests,
			checkCount, errorCount);
		if (errorCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== wbController.sv ====
module wbController import rvPkg::*;
(
	input logic clk,
	input logic reset,
	exBus.sink exIn,
	output logic regWriteEnable,
	output dataT regWriteData,
	output logic pcWriteEnable,
	output addrT pcWriteData
);

	logic regWriteNext;
	logic pcWriteNext;
	logic branchTaken;

	assign branchTaken = exIn.result[0]; // compare result from the alu

	// decide which writes this entry makes
	always_comb
	begin
		regWriteNext = 1'b0;
		pcWriteNext = 1'b0;
		case (exIn.kind)
			REGWRITE: regWriteNext = 1'b1;
			BRANCH: pcWriteNext = branchTaken;
			JUMP:
			begin
				regWriteNext = 1'b1; // rd gets pc + 4
				pcWriteNext = 1'b1;
			end
			default:
			begin
				regWriteNext = 1'b0;
				pcWriteNext = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			regWriteEnable <= 1'b0;
			pcWriteEnable <= 1'b0;
		end
		else
		begin
			regWriteEnable <= regWriteNext;
			pcWriteEnable <= pcWriteNext;
		end
	end

	always_ff @(posedge clk)
	begin
		regWriteData <= (exIn.kind == JUMP) ? exIn.link : exIn.result;
		pcWriteData <= exIn.target;
	end

endmodule
